//--- common/fetch_consts.svh
//////////////////////////////////////////////////
// Constants for the instruction fetch front end
// Include where widths, NOP words, error tags or
// the reset vector are needed
//////////////////////////////////////////////////

`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Address and instruction width
`define FETCH_XLEN 32

// First fetch address out of reset
`define FETCH_RESET_PC 32'h0000_0100

//////////////////////////////////////////////////
// NOP encodings
//////////////////////////////////////////////////

// Squashed, flushed or stale slot
`define FETCH_NOP_BUBBLE 32'h1441_0000
// No response on the port
`define FETCH_NOP_EMPTY 32'h1461_0000

//////////////////////////////////////////////////
// Error tags from the instruction memory
//////////////////////////////////////////////////

`define FETCH_TAG_TE 4'hd
`define FETCH_TAG_PE 4'hc
`define FETCH_TAG_BE 4'hb

`endif

//--- common/fetch_pkg.sv
//////////////////////////////////////////////////
// Shared types of the fetch front end
// Memory request and response, fetch slot,
// decode slot and the exception code
// Import with a wildcard in the module header
//////////////////////////////////////////////////

`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

	// Request to the instruction memory, held as a level
	typedef struct packed {
		logic [`FETCH_XLEN-1:0] addr;
		// Echoed back by the memory
		logic                   epoch;
		logic                   valid;
	} fetch_req_t;

	// Response from the instruction memory
	typedef struct packed {
		logic [`FETCH_XLEN-1:0] dat;
		// Echo of the request
		logic [`FETCH_XLEN-1:0] addr;
		logic                   epoch;
		// One-cycle pulses
		logic                   ack;
		logic                   err;
		logic [3:0]             tag;
	} imem_rsp_t;

	// Fetch stage output
	typedef struct packed {
		logic [`FETCH_XLEN-1:0] insn;
		logic [`FETCH_XLEN-1:0] pc;
		logic                   tlb_miss;
		logic                   page_fault;
		logic                   bus_err;
	} fetch_slot_t;

	// Encoded fetch exception
	typedef enum logic [1:0] {
		EXC_NONE = 2'd0,
		EXC_ITLB = 2'd1,
		EXC_IMMU = 2'd2,
		EXC_IBUS = 2'd3
	} exc_code_t;

	// IF/ID register contents seen by decode
	typedef struct packed {
		logic                   valid;
		logic [`FETCH_XLEN-1:0] insn;
		logic [`FETCH_XLEN-1:0] pc;
		exc_code_t              exc;
	} dec_slot_t;

endpackage

`default_nettype wire

//--- verilog/fetch_pc_gen.sv
//////////////////////////////////////////////////
// Program counter and fetch request generator
// Presents one request at a time to the memory
// Advances on an accepted response, holds on a
// refetch, redirects and toggles epoch on flush
//////////////////////////////////////////////////

`default_nettype none

`include "fetch_consts.svh"

module fetch_pc_gen
	import fetch_pkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   rst_n_i,

	// From the fetch stage
	input  wire logic                   accept_i,
	input  wire logic                   refetch_i,

	// Pipeline redirect
	input  wire logic                   flush_i,
	input  wire logic [`FETCH_XLEN-1:0] flush_pc_i,

	// To the instruction memory
	output fetch_req_t                  req_o
);

	//////////////////////////////////////////////////
	// State
	//////////////////////////////////////////////////

	// Current fetch address, word aligned
	logic [`FETCH_XLEN-1:0] pc_q;
	// Flips on every redirect
	logic                   epoch_q;

	// Next sequential address
	logic [`FETCH_XLEN-1:0] pc_seq;
	// Redirect target with low bits cleared
	logic [`FETCH_XLEN-1:0] pc_tgt;

	assign pc_seq = pc_q + `FETCH_XLEN'd4;
	assign pc_tgt = {flush_pc_i[`FETCH_XLEN-1:2], 2'b00};

	//////////////////////////////////////////////////
	// PC and epoch update
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_q    <= `FETCH_RESET_PC;
			epoch_q <= 1'b0;
		end else if (flush_i) begin
			// Redirect wins over any response this cycle
			pc_q    <= pc_tgt;
			// In-flight responses now carry the old epoch
			epoch_q <= ~epoch_q;
		end else if (refetch_i) begin
			// Response was discarded, ask for it again
			pc_q    <= pc_q;
		end else if (accept_i) begin
			pc_q    <= pc_seq;
		end
	end

	//////////////////////////////////////////////////
	// Request to memory
	//////////////////////////////////////////////////

	// Stable until the next advance or redirect
	assign req_o.addr  = pc_q;
	assign req_o.epoch = epoch_q;
	// One request is always outstanding
	assign req_o.valid = 1'b1;

endmodule

`default_nettype wire

//--- fetch/fetch_stage.sv
//////////////////////////////////////////////////
// Instruction fetch stage
// Turns each memory response into an instruction,
// PC and exception flags for the IF/ID register
// Saves one response under freeze, drops stale
// epochs, requests a refetch when a saved entry
// is pending, and squashes to a bubble NOP
//////////////////////////////////////////////////

`default_nettype none

`include "fetch_consts.svh"

module fetch_stage
	import fetch_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst_n_i,

	// Memory response and the epoch now requested
	input  imem_rsp_t  rsp_i,
	input  wire logic  cur_epoch_i,

	// Pipeline controls
	input  wire logic  freeze_i,
	input  wire logic  flush_i,
	input  wire logic  squash_i,

	// To the IF/ID register
	output fetch_slot_t slot_o,
	output logic       slot_live_o,

	// To the PC generator
	output logic       accept_o,
	output logic       refetch_o,
	output logic       stall_o
);

	//////////////////////////////////////////////////
	// Response qualification
	//////////////////////////////////////////////////

	logic rsp_hit;
	logic rsp_stale;
	logic rsp_fresh;
	logic save;

	// Decoded error flags of the live response
	logic tlb_miss;
	logic page_fault;
	logic bus_err;

	// Saved entry
	logic                   saved_q;
	logic [`FETCH_XLEN-1:0] insn_saved;
	logic [`FETCH_XLEN-1:0] pc_saved;
	logic [2:0]             err_saved;

	// Any response this cycle
	assign rsp_hit   = rsp_i.ack | rsp_i.err;
	// Issued before the last redirect
	assign rsp_stale = rsp_hit & (rsp_i.epoch != cur_epoch_i);
	assign rsp_fresh = rsp_hit & ~rsp_stale;

	// Only the first response under freeze is kept
	assign save = rsp_fresh & freeze_i & ~saved_q & ~flush_i;

	assign tlb_miss   = rsp_fresh & rsp_i.err & (rsp_i.tag == `FETCH_TAG_TE);
	assign page_fault = rsp_fresh & rsp_i.err & (rsp_i.tag == `FETCH_TAG_PE);
	assign bus_err    = rsp_fresh & rsp_i.err & (rsp_i.tag == `FETCH_TAG_BE);

	//////////////////////////////////////////////////
	// Saved entry
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			saved_q <= 1'b0;
		end else if (flush_i) begin
			saved_q <= 1'b0;
		end else if (save) begin
			saved_q <= 1'b1;
		end else if (!freeze_i) begin
			// Handed on in the first unfrozen cycle
			saved_q <= 1'b0;
		end
	end

	// Payload only, qualified by saved_q
	always_ff @(posedge clk) begin
		if (save) begin
			insn_saved <= rsp_i.err ? `FETCH_NOP_BUBBLE : rsp_i.dat;
			pc_saved   <= {rsp_i.addr[`FETCH_XLEN-1:2], 2'b00};
			err_saved  <= {bus_err, page_fault, tlb_miss};
		end
	end

	//////////////////////////////////////////////////
	// Slot output
	//////////////////////////////////////////////////

	always_comb begin
		// Instruction word, bubbles first
		if (squash_i) begin
			slot_o.insn = `FETCH_NOP_BUBBLE;
		end else if (saved_q) begin
			slot_o.insn = insn_saved;
		end else if (rsp_stale) begin
			slot_o.insn = `FETCH_NOP_BUBBLE;
		end else if (rsp_i.err) begin
			slot_o.insn = `FETCH_NOP_BUBBLE;
		end else if (rsp_i.ack) begin
			slot_o.insn = rsp_i.dat;
		end else begin
			slot_o.insn = `FETCH_NOP_EMPTY;
		end

		slot_o.pc = saved_q ? pc_saved : {rsp_i.addr[`FETCH_XLEN-1:2], 2'b00};

		// Squash also hides exceptions
		if (squash_i) begin
			slot_o.tlb_miss   = 1'b0;
			slot_o.page_fault = 1'b0;
			slot_o.bus_err    = 1'b0;
		end else if (saved_q) begin
			slot_o.tlb_miss   = err_saved[0];
			slot_o.page_fault = err_saved[1];
			slot_o.bus_err    = err_saved[2];
		end else begin
			slot_o.tlb_miss   = tlb_miss;
			slot_o.page_fault = page_fault;
			slot_o.bus_err    = bus_err;
		end
	end

	// Real instruction for decode
	assign slot_live_o = ~squash_i & (saved_q | rsp_fresh);

	//////////////////////////////////////////////////
	// Flow control
	//////////////////////////////////////////////////

	// Passed on, or captured under freeze
	assign accept_o  = rsp_fresh & ~saved_q;
	// Saved slot occupied, so this one is lost
	assign refetch_o = rsp_fresh & saved_q;
	// Nothing to hand on
	assign stall_o   = ~rsp_hit & ~saved_q;

endmodule

`default_nettype wire

//--- verilog/fetch_decode_reg.sv
//////////////////////////////////////////////////
// IF/ID pipeline register
// Loads the fetch slot on every unfrozen cycle,
// holds under freeze and bubbles on flush
// Encodes the fetch exception flags by priority
//////////////////////////////////////////////////

`default_nettype none

`include "fetch_consts.svh"

module fetch_decode_reg
	import fetch_pkg::*;
(
	input  wire logic  clk,
	input  wire logic  rst_n_i,

	// From the fetch stage
	input  fetch_slot_t slot_i,
	input  wire logic  slot_live_i,

	// Pipeline controls
	input  wire logic  freeze_i,
	input  wire logic  flush_i,

	// To decode
	output dec_slot_t  dec_o
);

	logic                   valid_q;
	logic [`FETCH_XLEN-1:0] insn_q;
	logic [`FETCH_XLEN-1:0] pc_q;
	exc_code_t              exc_q;
	exc_code_t              exc_next;

	// TLB miss above page fault above bus error
	always_comb begin
		if (slot_i.tlb_miss) begin
			exc_next = EXC_ITLB;
		end else if (slot_i.page_fault) begin
			exc_next = EXC_IMMU;
		end else if (slot_i.bus_err) begin
			exc_next = EXC_IBUS;
		end else begin
			exc_next = EXC_NONE;
		end
	end

	//////////////////////////////////////////////////
	// Register update
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			valid_q <= 1'b0;
		end else if (flush_i) begin
			valid_q <= 1'b0;
		end else if (!freeze_i) begin
			valid_q <= slot_live_i;
		end
	end

	// Payload follows valid, no reset
	always_ff @(posedge clk) begin
		if (flush_i) begin
			insn_q <= `FETCH_NOP_BUBBLE;
			exc_q  <= EXC_NONE;
		end else if (!freeze_i) begin
			insn_q <= slot_i.insn;
			pc_q   <= slot_i.pc;
			exc_q  <= exc_next;
		end
	end

	assign dec_o.valid = valid_q;
	assign dec_o.insn  = insn_q;
	assign dec_o.pc    = pc_q;
	assign dec_o.exc   = exc_q;

endmodule

`default_nettype wire

//--- verilog/fetch_unit.sv
//////////////////////////////////////////////////
// Instruction fetch front end, top level
// PC generator drives the memory request, the
// fetch stage qualifies responses, and the IF/ID
// register presents them to decode
//////////////////////////////////////////////////

`default_nettype none

`include "fetch_consts.svh"

module fetch_unit
	import fetch_pkg::*;
(
	input  wire logic                   clk,
	input  wire logic                   rst_n_i,

	// Instruction memory port
	output fetch_req_t                  imem_req_o,
	input  imem_rsp_t                   imem_rsp_i,

	// Pipeline controls
	input  wire logic                   freeze_i,
	input  wire logic                   flush_i,
	input  wire logic                   squash_i,
	input  wire logic [`FETCH_XLEN-1:0] flush_pc_i,

	// To decode
	output dec_slot_t                   dec_o,
	output logic                        stall_o
);

	// Fetch stage to IF/ID
	fetch_slot_t slot;
	logic        slot_live;

	// Fetch stage to PC generator
	logic        accept;
	logic        refetch;

	//////////////////////////////////////////////////
	// Request side
	//////////////////////////////////////////////////

	fetch_pc_gen u_pc_gen (
		.clk        (clk),
		.rst_n_i    (rst_n_i),
		.accept_i   (accept),
		.refetch_i  (refetch),
		.flush_i    (flush_i),
		.flush_pc_i (flush_pc_i),
		.req_o      (imem_req_o)
	);

	//////////////////////////////////////////////////
	// Response processing
	//////////////////////////////////////////////////

	// Epoch of the live request decides staleness
	fetch_stage u_stage (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.rsp_i       (imem_rsp_i),
		.cur_epoch_i (imem_req_o.epoch),
		.freeze_i    (freeze_i),
		.flush_i     (flush_i),
		.squash_i    (squash_i),
		.slot_o      (slot),
		.slot_live_o (slot_live),
		.accept_o    (accept),
		.refetch_o   (refetch),
		.stall_o     (stall_o)
	);

	// IF/ID register
	fetch_decode_reg u_dec_reg (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.slot_i      (slot),
		.slot_live_i (slot_live),
		.freeze_i    (freeze_i),
		.flush_i     (flush_i),
		.dec_o       (dec_o)
	);

endmodule

`default_nettype wire

//--- testbench/imem_model.sv
//////////////////////////////////////////////////
// Behavioral instruction memory for the testbench
// Latches the presented request, waits a random
// 0 to max_wait_i cycles, then pulses ack or err
// Three addresses answer err with a TE, PE or BE tag
//////////////////////////////////////////////////

`default_nettype none

`include "fetch_consts.svh"

module imem_model
	import fetch_pkg::*;
#(
	parameter logic [`FETCH_XLEN-1:0] TE_ADDR = 32'h0,
	parameter logic [`FETCH_XLEN-1:0] PE_ADDR = 32'h0,
	parameter logic [`FETCH_XLEN-1:0] BE_ADDR = 32'h0
) (
	input  wire logic       clk,
	input  wire logic       rst_n_i,
	// Upper bound of the random wait
	input  wire logic [1:0] max_wait_i,
	input  wire fetch_req_t req_i,
	output imem_rsp_t       rsp_o
);

	logic                   busy;
	logic [1:0]             wait_cnt;
	logic [`FETCH_XLEN-1:0] lat_addr;
	logic                   lat_epoch;
	int                     draw;

	// Error table lookup, zero means a normal fetch
	function automatic logic [3:0] tag_at(input logic [`FETCH_XLEN-1:0] a);
		if (a == TE_ADDR) return `FETCH_TAG_TE;
		if (a == PE_ADDR) return `FETCH_TAG_PE;
		if (a == BE_ADDR) return `FETCH_TAG_BE;
		return 4'h0;
	endfunction

	// Response word for one request
	function automatic imem_rsp_t answer(input logic [`FETCH_XLEN-1:0] a, input logic ep);
		imem_rsp_t r;
		logic [3:0] tag;
		tag     = tag_at(a);
		// Garbage data on error, the fetch stage must replace it
		r.dat   = (tag != 4'h0) ? ~a : (a ^ 32'h5a5a_0000);
		r.addr  = a;
		r.epoch = ep;
		r.ack   = (tag == 4'h0);
		r.err   = (tag != 4'h0);
		r.tag   = tag;
		return r;
	endfunction

	always @(posedge clk) begin
		if (!rst_n_i) begin
			rsp_o    <= '0;
			busy     <= 1'b0;
			wait_cnt <= 2'd0;
		end else if (rsp_o.ack || rsp_o.err) begin
			// Request moves on at this edge, sample it next time
			rsp_o <= '0;
		end else if (busy) begin
			if (wait_cnt == 2'd0) begin
				rsp_o <= answer(lat_addr, lat_epoch);
				busy  <= 1'b0;
			end else begin
				wait_cnt <= wait_cnt - 2'd1;
			end
		end else if (req_i.valid) begin
			draw = int'($urandom % (32'(max_wait_i) + 32'd1));
			if (draw == 0) begin
				rsp_o <= answer(req_i.addr, req_i.epoch);
			end else begin
				busy      <= 1'b1;
				wait_cnt  <= 2'(draw - 1);
				lat_addr  <= req_i.addr;
				lat_epoch <= req_i.epoch;
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/fetch_tb.sv
//////////////////////////////////////////////////
// Testbench for the instruction fetch front end
// Directed tests drive freeze, flush and squash
// A falling edge monitor scores every decode slot
// against the memory rule and the expected PC order
//////////////////////////////////////////////////

`default_nettype none

`include "fetch_consts.svh"

module fetch_tb
	import fetch_pkg::*;
();

	// Error addresses seeded in the memory
	localparam logic [`FETCH_XLEN-1:0] TE_ADDR = 32'h0000_3000;
	localparam logic [`FETCH_XLEN-1:0] PE_ADDR = 32'h0000_3008;
	localparam logic [`FETCH_XLEN-1:0] BE_ADDR = 32'h0000_3010;

	// Test lengths, in decode entries or cycles
	localparam int LEN_SEQ       = 16;
	localparam int LEN_WAIT      = 24;
	localparam int LEN_FREEZE    = 40;
	localparam int FLUSHES       = 6;
	localparam int LEN_FLUSH     = FLUSHES * 4;
	localparam int LEN_ERR       = 10;
	localparam int SQUASH_CYCLES = 24;
	localparam int LEN_SQUASH    = SQUASH_CYCLES + 4;
	localparam int WATCHDOG_CYCLES =
		8 * (LEN_SEQ + LEN_WAIT + LEN_FREEZE + LEN_FLUSH + LEN_ERR + LEN_SQUASH);

	logic                   clk;
	logic                   rst_n;
	logic                   freeze;
	logic                   flush;
	logic                   squash;
	logic [`FETCH_XLEN-1:0] flush_pc;
	logic [1:0]             max_wait;
	fetch_req_t             imem_req;
	imem_rsp_t              imem_rsp;
	dec_slot_t              dec;
	logic                   stall;

	// Scoreboard
	string                  test_name = "reset";
	int                     checks = 0;
	int                     errors = 0;
	int                     entries = 0;
	int                     squashed = 0;
	int                     sq_err = 0;
	int                     saves = 0;
	int                     refetches = 0;
	int                     itlb_seen = 0;
	int                     immu_seen = 0;
	int                     ibus_seen = 0;
	logic                   track_seq = 1'b1;
	logic [`FETCH_XLEN-1:0] exp_pc = `FETCH_RESET_PC;
	logic [`FETCH_XLEN-1:0] last_pc = '0;
	// Expected saved entry of the fetch stage
	logic                   saved_m = 1'b0;

	// Controls and slot at the previous falling edge
	logic                   flush_p = 1'b0;
	logic                   freeze_p = 1'b0;
	logic                   squash_p = 1'b0;
	logic                   epoch_p = 1'b0;
	dec_slot_t              dec_p;

	fetch_unit dut (
		.clk        (clk),
		.rst_n_i    (rst_n),
		.imem_req_o (imem_req),
		.imem_rsp_i (imem_rsp),
		.freeze_i   (freeze),
		.flush_i    (flush),
		.squash_i   (squash),
		.flush_pc_i (flush_pc),
		.dec_o      (dec),
		.stall_o    (stall)
	);

	imem_model #(
		.TE_ADDR (TE_ADDR),
		.PE_ADDR (PE_ADDR),
		.BE_ADDR (BE_ADDR)
	) imem (
		.clk        (clk),
		.rst_n_i    (rst_n),
		.max_wait_i (max_wait),
		.req_i      (imem_req),
		.rsp_o      (imem_rsp)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// Expected values and scoring
	//////////////////////////////////////////////////

	function automatic exc_code_t exc_at(input logic [`FETCH_XLEN-1:0] pc);
		if (pc == TE_ADDR) return EXC_ITLB;
		if (pc == PE_ADDR) return EXC_IMMU;
		if (pc == BE_ADDR) return EXC_IBUS;
		return EXC_NONE;
	endfunction

	// Faulting fetches carry the bubble NOP
	function automatic logic [`FETCH_XLEN-1:0] insn_at(input logic [`FETCH_XLEN-1:0] pc);
		if (exc_at(pc) != EXC_NONE) return `FETCH_NOP_BUBBLE;
		return pc ^ 32'h5a5a_0000;
	endfunction

	task automatic check(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("mismatch %s %s: expected %h actual %h",
				test_name, what, expected, actual);
		end
	endtask

	task automatic score_entry();
		entries++;
		last_pc = dec.pc;
		if (track_seq) begin
			check("pc order", exp_pc, dec.pc);
			// Resync so one slip gives one error
			exp_pc = dec.pc + 32'd4;
		end
		check("insn", insn_at(dec.pc), dec.insn);
		check("exc", 32'(exc_at(dec.pc)), 32'(dec.exc));
		case (dec.exc)
			EXC_ITLB: itlb_seen++;
			EXC_IMMU: immu_seen++;
			EXC_IBUS: ibus_seen++;
			default: ;
		endcase
	endtask

	// Slot loaded at the last rising edge is stable here
	always @(negedge clk) begin
		logic hit;
		logic fresh;
		hit   = imem_rsp.ack | imem_rsp.err;
		fresh = hit && (imem_rsp.epoch == imem_req.epoch);
		if (rst_n) begin
			if (flush_p) begin
				check("valid after flush", 32'd0, 32'(dec.valid));
				check("req addr after flush", exp_pc, imem_req.addr);
				check("req epoch after flush", 32'(!epoch_p), 32'(imem_req.epoch));
			end else if (freeze_p) begin
				check("valid held", 32'(dec_p.valid), 32'(dec.valid));
				check("insn held", dec_p.insn, dec.insn);
				check("pc held", dec_p.pc, dec.pc);
				check("exc held", 32'(dec_p.exc), 32'(dec.exc));
			end else if (squash_p) begin
				check("valid under squash", 32'd0, 32'(dec.valid));
				check("exc under squash", 32'(EXC_NONE), 32'(dec.exc));
			end else if (dec.valid) begin
				score_entry();
			end
			// Idle port and nothing saved
			check("stall", 32'(!hit && !saved_m), 32'(stall));
			// Fresh response while squashed
			if (squash && fresh) begin
				if (imem_rsp.err) begin
					sq_err++;
				end else begin
					squashed++;
				end
			end
			// Saved slot busy, this response must come again
			if (fresh && saved_m && !flush) begin
				refetches++;
			end
			// One saved entry under freeze, cleared when unfrozen
			if (flush) begin
				saved_m = 1'b0;
			end else if (fresh && freeze && !saved_m) begin
				saved_m = 1'b1;
				saves++;
			end else if (!freeze) begin
				saved_m = 1'b0;
			end
			if (flush) begin
				exp_pc = {flush_pc[`FETCH_XLEN-1:2], 2'b00};
			end
		end
		flush_p  = flush;
		freeze_p = freeze;
		squash_p = squash;
		epoch_p  = imem_req.epoch;
		dec_p    = dec;
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	// Returns on a rising edge once n more entries are in
	task automatic await_entries(input int n);
		int target;
		target = entries + n;
		while (entries < target) begin
			@(posedge clk);
		end
	endtask

	task automatic redirect(input logic [`FETCH_XLEN-1:0] target);
		@(posedge clk);
		flush    <= 1'b1;
		flush_pc <= target;
		@(posedge clk);
		flush    <= 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////

	task automatic sequential_fetch();
		test_name = "sequential";
		max_wait <= 2'd0;
		await_entries(LEN_SEQ);
	endtask

	// Same stream from the reset vector, now with waits
	task automatic wait_state_fetch();
		test_name = "wait states";
		max_wait <= 2'd3;
		redirect(`FETCH_RESET_PC);
		await_entries(LEN_WAIT);
	endtask

	task automatic freeze_stretches();
		int target;
		int len;
		test_name = "freeze";
		target = entries + LEN_FREEZE;
		while (entries < target) begin
			@(posedge clk);
			freeze <= (($urandom % 2) == 0);
			len = 1 + int'($urandom % 4);
			repeat (len - 1) @(posedge clk);
		end
		@(posedge clk);
		freeze <= 1'b0;
		check("saves seen", 32'd1, 32'(saves > 0));
		check("refetches seen", 32'd1, 32'(refetches > 0));
	endtask

	task automatic flush_redirects();
		logic [`FETCH_XLEN-1:0] target;
		test_name = "flush";
		repeat (FLUSHES) begin
			repeat ($urandom % 4) @(posedge clk);
			target = 32'h0000_4000 + {20'd0, 10'($urandom % 1024), 2'b00};
			redirect(target);
			await_entries(1);
			check("first pc after flush", target, last_pc);
			await_entries(3);
		end
	endtask

	task automatic error_tag_fetch();
		int itlb0;
		int immu0;
		int ibus0;
		test_name = "error tags";
		itlb0 = itlb_seen;
		immu0 = immu_seen;
		ibus0 = ibus_seen;
		redirect(TE_ADDR - 32'd8);
		await_entries(LEN_ERR);
		check("itlb entries", itlb0 + 1, itlb_seen);
		check("immu entries", immu0 + 1, immu_seen);
		check("ibus entries", ibus0 + 1, ibus_seen);
	endtask

	// Error address fetched first while squash is high
	task automatic squash_window();
		test_name = "squash";
		track_seq = 1'b0;
		@(posedge clk);
		squash   <= 1'b1;
		flush    <= 1'b1;
		flush_pc <= TE_ADDR;
		@(posedge clk);
		flush    <= 1'b0;
		repeat (SQUASH_CYCLES - 1) @(posedge clk);
		squash   <= 1'b0;
		check("error fetched under squash", 32'd1, 32'(sq_err > 0));
		check("squashed fetches seen", 32'd1, 32'(squashed > 0));
		await_entries(4);
	endtask

	//////////////////////////////////////////////////
	// Run control
	//////////////////////////////////////////////////

	initial begin : main
		int seed_ret;
		seed_ret = $urandom(32'hed9b_b71c);
		rst_n    <= 1'b0;
		freeze   <= 1'b0;
		flush    <= 1'b0;
		squash   <= 1'b0;
		flush_pc <= '0;
		max_wait <= 2'd0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check("valid after reset", 32'd0, 32'(dec.valid));
		check("req addr after reset", `FETCH_RESET_PC, imem_req.addr);
		check("req epoch after reset", 32'd0, 32'(imem_req.epoch));
		check("req valid after reset", 32'd1, 32'(imem_req.valid));
		sequential_fetch();
		wait_state_fetch();
		freeze_stretches();
		flush_redirects();
		error_tag_fetch();
		squash_window();
		$display("checks %0d, entries %0d, errors %0d", checks, entries, errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: test %s still running after %0d cycles",
			test_name, WATCHDOG_CYCLES);
		$display("checks %0d, entries %0d, errors %0d", checks, entries, errors);
		$display("** FAIL **");
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
+incdir+common
common/fetch_pkg.sv
verilog/fetch_pc_gen.sv
fetch/fetch_stage.sv
verilog/fetch_decode_reg.sv
verilog/fetch_unit.sv
testbench/imem_model.sv
testbench/fetch_tb.sv

//--- Makefile
# Verilator build and run of the fetch front end testbench
# The run passes only when the pass line shows up in the output

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the fetch testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module fetch_tb -f files.f -Mdir obj_dir
	@out="$$(./obj_dir/Vfetch_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF '** PASS **'

clean:
	rm -rf obj_dir
